/* design/fifo_status_pkg.sv */
// ------------------------------
// shared types for the FIFO status flag controller
// the flag struct order is fixed and the testbench relies on it
// count_width covers zero to depth inclusive, so one extra bit
// ------------------------------

package fifo_status_pkg;

  // ------------------------------
  // status flags
  // ------------------------------

  // seven single bit flags, empty end first
  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic prog_empty;
    logic half_full;
    logic full;
    logic almost_full;
    logic prog_full;
  } fifo_flags_t;

  // ------------------------------
  // fill regions
  // ------------------------------

  // encoding order matters since neighbours differ by one
  typedef enum logic [1:0] {
    EMPTY_ST      = 2'd0,
    BELOW_HALF_ST = 2'd1,
    AT_HALF_ST    = 2'd2,
    FULL_ST       = 2'd3
  } fill_state_e;

  // bits needed to hold 0 up to depth, floor(log2(depth)) + 1
  function automatic int count_width(input int depth);
    int width;
    int range;
    width = 1;
    range = depth;
    // one bit per halving step
    while (range > 1) begin
      range = range >> 1;
      width = width + 1;
    end
    return width;
  endfunction

endpackage

/* design/fifo_occupancy_counter.sv */
// ------------------------------
// occupancy count of a single clock FIFO
// wr_i and rd_i are accepted transfers, one word each per cycle
// no wrap handling, the count saturates by protocol only
// a lone write at DEPTH or a lone read at zero is illegal
// ------------------------------

`timescale 1ns/100ps

module fifo_occupancy_counter #(
  parameter int DEPTH = 16
) (
  input  logic                                           clk_i,
  input  logic                                           a_rst_i,
  input  logic                                           wr_i,
  input  logic                                           rd_i,
  output logic [fifo_status_pkg::count_width(DEPTH)-1:0] count_o
);

  localparam int CW = fifo_status_pkg::count_width(DEPTH);

  // count value when every word is in use
  localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);

  logic [CW-1:0] count_q;

  // ------------------------------
  // count register
  // ------------------------------

  // write and read in the same cycle cancel out
  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      count_q <= '0;
    end else begin
      case ({wr_i, rd_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // new value visible in the cycle after the strobe
  assign count_o = count_q;

  // ------------------------------
  // protocol checks
  // ------------------------------

  // no write into a full FIFO unless a read frees a word
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (a_rst_i)
    !(wr_i && !rd_i && (count_q == FULL_COUNT))
  );

  // no read from an empty FIFO
  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (a_rst_i)
    !(rd_i && !wr_i && (count_q == '0))
  );

endmodule

/* design/fifo_fill_fsm.sv */
// ------------------------------
// four region fill state machine for empty, half full and full
// relies on the count moving by at most one per cycle
// outputs decode the next state, so they match the count
// in the same cycle and add no latency
// half full means count >= DEPTH/2 rounded down
// ------------------------------

`timescale 1ns/100ps

module fifo_fill_fsm #(
  parameter int DEPTH = 16
) (
  input  logic                                           clk_i,
  input  logic                                           a_rst_i,
  input  logic [fifo_status_pkg::count_width(DEPTH)-1:0] count_i,
  output fifo_status_pkg::fill_state_e                   state_next_o,
  output logic                                           empty_o,
  output logic                                           half_full_o,
  output logic                                           full_o
);

  localparam int CW = fifo_status_pkg::count_width(DEPTH);
  localparam int HALF_DEPTH = DEPTH / 2;

  localparam logic [CW-1:0] HALF_COUNT = CW'(HALF_DEPTH);
  localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);

  fifo_status_pkg::fill_state_e curr_st;
  fifo_status_pkg::fill_state_e next_st;

  // ------------------------------
  // next state and flag decode
  // ------------------------------

  always_comb begin
    next_st = curr_st;
    case (curr_st)
      fifo_status_pkg::EMPTY_ST: begin
        // first word may already reach half when DEPTH is 2 or 3
        if (count_i != '0) begin
          if (count_i >= HALF_COUNT) begin
            next_st = fifo_status_pkg::AT_HALF_ST;
          end else begin
            next_st = fifo_status_pkg::BELOW_HALF_ST;
          end
        end
      end
      fifo_status_pkg::BELOW_HALF_ST: begin
        if (count_i == '0) begin
          next_st = fifo_status_pkg::EMPTY_ST;
        end else if (count_i >= HALF_COUNT) begin
          next_st = fifo_status_pkg::AT_HALF_ST;
        end
      end
      fifo_status_pkg::AT_HALF_ST: begin
        // zero only reachable from here when the below region is empty
        if (count_i == FULL_COUNT) begin
          next_st = fifo_status_pkg::FULL_ST;
        end else if (count_i == '0) begin
          next_st = fifo_status_pkg::EMPTY_ST;
        end else if (count_i < HALF_COUNT) begin
          next_st = fifo_status_pkg::BELOW_HALF_ST;
        end
      end
      fifo_status_pkg::FULL_ST: begin
        // DEPTH-1 is always at or above half
        if (count_i != FULL_COUNT) begin
          next_st = fifo_status_pkg::AT_HALF_ST;
        end
      end
      default: begin
        next_st = fifo_status_pkg::EMPTY_ST;
      end
    endcase

    // flags follow the region the count is in now
    empty_o     = (next_st == fifo_status_pkg::EMPTY_ST);
    half_full_o = (next_st == fifo_status_pkg::AT_HALF_ST) ||
                  (next_st == fifo_status_pkg::FULL_ST);
    full_o      = (next_st == fifo_status_pkg::FULL_ST);
  end

  // ------------------------------
  // state register
  // ------------------------------

  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      curr_st <= fifo_status_pkg::EMPTY_ST;
    end else begin
      curr_st <= next_st;
    end
  end

  // threshold block forces its flags at the ends
  assign state_next_o = next_st;

  // ------------------------------
  // checks
  // ------------------------------

  // one step per cycle between neighbouring regions
  // skipped when the below half region has no counts
  a_adjacent_step: assert property (
    @(posedge clk_i) disable iff (a_rst_i)
    (HALF_DEPTH > 1) |->
      ((int'(curr_st) - int'($past(curr_st))) inside {-1, 0, 1})
  );

endmodule

/* design/fifo_threshold_flags.sv */
// ------------------------------
// almost flags and programmable flags with hysteresis
// prog full rises at PROG_FULL_ASSERT and holds down to
// PROG_FULL_NEGATE, prog empty mirrors this at the low end
// equal assert and negate levels give a single threshold
// both flags are forced at the empty and full ends
// ------------------------------

`timescale 1ns/100ps

module fifo_threshold_flags #(
  parameter int DEPTH             = 16,
  parameter int PROG_FULL_ASSERT  = 12,
  parameter int PROG_FULL_NEGATE  = 10,
  parameter int PROG_EMPTY_ASSERT = 2,
  parameter int PROG_EMPTY_NEGATE = 4
) (
  input  logic                                           clk_i,
  input  logic                                           a_rst_i,
  input  logic [fifo_status_pkg::count_width(DEPTH)-1:0] count_i,
  input  fifo_status_pkg::fill_state_e                   state_next_i,
  output logic                                           almost_empty_o,
  output logic                                           almost_full_o,
  output logic                                           prog_empty_o,
  output logic                                           prog_full_o
);

  localparam int CW = fifo_status_pkg::count_width(DEPTH);

  // levels sized to the count so compares stay in one width
  localparam logic [CW-1:0] ONE_COUNT   = CW'(1);
  localparam logic [CW-1:0] AFULL_COUNT = CW'(DEPTH - 1);
  localparam logic [CW-1:0] PF_ASSERT   = CW'(PROG_FULL_ASSERT);
  localparam logic [CW-1:0] PF_NEGATE   = CW'(PROG_FULL_NEGATE);
  localparam logic [CW-1:0] PE_ASSERT   = CW'(PROG_EMPTY_ASSERT);
  localparam logic [CW-1:0] PE_NEGATE   = CW'(PROG_EMPTY_NEGATE);

  logic at_empty;
  logic at_full;

  // last cycle's programmable flags
  logic prog_full_q;
  logic prog_empty_q;

  assign at_empty = (state_next_i == fifo_status_pkg::EMPTY_ST);
  assign at_full  = (state_next_i == fifo_status_pkg::FULL_ST);

  // ------------------------------
  // almost flags
  // ------------------------------

  // one word or none left
  assign almost_empty_o = at_full  ? 1'b0 :
                          at_empty ? 1'b1 : (count_i <= ONE_COUNT);

  // one free slot or none
  assign almost_full_o  = at_empty ? 1'b0 :
                          at_full  ? 1'b1 : (count_i >= AFULL_COUNT);

  // ------------------------------
  // programmable flags
  // ------------------------------

  // a set flag is held by the negate level, a clear one waits for assert
  assign prog_full_o  = at_empty    ? 1'b0 :
                        at_full     ? 1'b1 :
                        prog_full_q ? (count_i >= PF_NEGATE) : (count_i >= PF_ASSERT);

  assign prog_empty_o = at_full      ? 1'b0 :
                        at_empty     ? 1'b1 :
                        prog_empty_q ? (count_i <= PE_NEGATE) : (count_i <= PE_ASSERT);

  // hysteresis state, matching the flags of an empty FIFO after reset
  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      prog_full_q  <= 1'b0;
      prog_empty_q <= 1'b1;
    end else begin
      prog_full_q  <= prog_full_o;
      prog_empty_q <= prog_empty_o;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // fill FSM and counter must agree on both ends
  a_ends_agree: assert property (
    @(posedge clk_i) disable iff (a_rst_i)
    ((count_i == '0) == at_empty) && ((count_i == CW'(DEPTH)) == at_full)
  );

endmodule

/* design/fifo_status_top.sv */
// ------------------------------
// status flag controller for a single clock FIFO
// observes accepted write and read strobes only
// all flags are valid in the same cycle as datacount_o
// DEPTH of 2 or more, PROG_FULL_NEGATE <= PROG_FULL_ASSERT,
// PROG_EMPTY_NEGATE >= PROG_EMPTY_ASSERT
// ------------------------------

`timescale 1ns/100ps

module fifo_status_top #(
  parameter int DEPTH             = 16,
  parameter int PROG_FULL_ASSERT  = 12,
  parameter int PROG_FULL_NEGATE  = 10,
  parameter int PROG_EMPTY_ASSERT = 2,
  parameter int PROG_EMPTY_NEGATE = 4
) (
  input  logic                                           clk_i,
  input  logic                                           a_rst_i,
  input  logic                                           wr_i,
  input  logic                                           rd_i,
  output logic [fifo_status_pkg::count_width(DEPTH)-1:0] datacount_o,
  output fifo_status_pkg::fifo_flags_t                   flags_o
);

  localparam int CW = fifo_status_pkg::count_width(DEPTH);

  logic [CW-1:0]                count;
  fifo_status_pkg::fill_state_e state_next;

  logic empty;
  logic half_full;
  logic full;
  logic almost_empty;
  logic almost_full;
  logic prog_empty;
  logic prog_full;

  // ------------------------------
  // blocks
  // ------------------------------

  fifo_occupancy_counter #(
    .DEPTH (DEPTH)
  ) u_counter (
    .clk_i   (clk_i),
    .a_rst_i (a_rst_i),
    .wr_i    (wr_i),
    .rd_i    (rd_i),
    .count_o (count)
  );

  fifo_fill_fsm #(
    .DEPTH (DEPTH)
  ) u_fill_fsm (
    .clk_i        (clk_i),
    .a_rst_i      (a_rst_i),
    .count_i      (count),
    .state_next_o (state_next),
    .empty_o      (empty),
    .half_full_o  (half_full),
    .full_o       (full)
  );

  fifo_threshold_flags #(
    .DEPTH             (DEPTH),
    .PROG_FULL_ASSERT  (PROG_FULL_ASSERT),
    .PROG_FULL_NEGATE  (PROG_FULL_NEGATE),
    .PROG_EMPTY_ASSERT (PROG_EMPTY_ASSERT),
    .PROG_EMPTY_NEGATE (PROG_EMPTY_NEGATE)
  ) u_thresholds (
    .clk_i          (clk_i),
    .a_rst_i        (a_rst_i),
    .count_i        (count),
    .state_next_i   (state_next),
    .almost_empty_o (almost_empty),
    .almost_full_o  (almost_full),
    .prog_empty_o   (prog_empty),
    .prog_full_o    (prog_full)
  );

  // ------------------------------
  // outputs
  // ------------------------------

  assign datacount_o = count;

  // struct order is empty end first
  always_comb begin
    flags_o.empty        = empty;
    flags_o.almost_empty = almost_empty;
    flags_o.prog_empty   = prog_empty;
    flags_o.half_full    = half_full;
    flags_o.full         = full;
    flags_o.almost_full  = almost_full;
    flags_o.prog_full    = prog_full;
  end

endmodule

/* testbench/tb_fifo_status.sv */
// ------------------------------
// testbench for the FIFO status flag controller
// DEPTH 8, prog full 6 and 4, prog empty 2 and 3
// directed table first, then legal random strobes
// expected flags come from the occupancy rules
// ------------------------------

`timescale 1ns/100ps

module tb_fifo_status;

  localparam int DEPTH          = 8;
  localparam int PF_ASR         = 6;
  localparam int PF_NEG         = 4;
  localparam int PE_ASR         = 2;
  localparam int PE_NEG         = 3;
  localparam int CW             = fifo_status_pkg::count_width(DEPTH);
  localparam int NUM_ROWS       = 23;
  localparam int RAND_CYCLES    = 300;
  localparam int TIMEOUT_CYCLES = NUM_ROWS + RAND_CYCLES + 50;

  // one directed step, flags in struct order with empty as msb
  typedef struct packed {
    logic [2:0]    test;
    logic          wr;
    logic          rd;
    logic [CW-1:0] count;
    logic [6:0]    flags;
  } row_t;

  logic                         clk_i;
  logic                         a_rst_i;
  logic                         wr_i;
  logic                         rd_i;
  logic [CW-1:0]                datacount_o;
  fifo_status_pkg::fifo_flags_t flags_o;

  row_t   rows [NUM_ROWS];
  int     row_n        = 0;
  integer seed         = 17939;
  int     cycles       = 0;
  int     checks       = 0;
  int     errors       = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;

  fifo_status_top #(
    .DEPTH             (DEPTH),
    .PROG_FULL_ASSERT  (PF_ASR),
    .PROG_FULL_NEGATE  (PF_NEG),
    .PROG_EMPTY_ASSERT (PE_ASR),
    .PROG_EMPTY_NEGATE (PE_NEG)
  ) u_dut (
    .clk_i       (clk_i),
    .a_rst_i     (a_rst_i),
    .wr_i        (wr_i),
    .rd_i        (rd_i),
    .datacount_o (datacount_o),
    .flags_o     (flags_o)
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // run limit, table plus random phase plus margin for reset
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------
  // reference rules
  // ------------------------------

  // flags for a count, given last cycle's programmable flags
  function automatic logic [6:0] rule_flags(input int count, input logic pf_prev,
                                            input logic pe_prev);
    logic [6:0] f;
    f[6] = (count == 0);
    f[5] = (count <= 1);
    // prog empty, held up to the negate level once set
    f[4] = pe_prev ? (count <= PE_NEG) : (count <= PE_ASR);
    f[3] = (count >= DEPTH / 2);
    f[2] = (count == DEPTH);
    f[1] = (count >= DEPTH - 1);
    // prog full, held down to the negate level once set
    f[0] = pf_prev ? (count >= PF_NEG) : (count >= PF_ASR);
    return f;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "fill to full";
      2:       return "drain to five and simultaneous strobes";
      3:       return "hysteresis";
      4:       return "drain to empty";
      default: return "random strobes";
    endcase
  endfunction

  // ------------------------------
  // checks and reporting
  // ------------------------------

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_outputs(input int exp_count, input logic [6:0] exp_flags);
    check_value("datacount_o", exp_count, int'(datacount_o));
    check_value("flags_o.empty", int'(exp_flags[6]), int'(flags_o.empty));
    check_value("flags_o.almost_empty", int'(exp_flags[5]), int'(flags_o.almost_empty));
    check_value("flags_o.prog_empty", int'(exp_flags[4]), int'(flags_o.prog_empty));
    check_value("flags_o.half_full", int'(exp_flags[3]), int'(flags_o.half_full));
    check_value("flags_o.full", int'(exp_flags[2]), int'(flags_o.full));
    check_value("flags_o.almost_full", int'(exp_flags[1]), int'(flags_o.almost_full));
    check_value("flags_o.prog_full", int'(exp_flags[0]), int'(flags_o.prog_full));
  endtask

  // one line per finished test, err_mark is the error count at its start
  task automatic report_test(input int id, inout int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d (%s) ok", id, test_name(id));
    end else begin
      tests_failed++;
      $display("test %0d (%s) FAILED with %0d errors", id, test_name(id), errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ------------------------------
  // directed table
  // ------------------------------

  task automatic add_row(input int test, input logic wr, input logic rd, input int count,
                         input logic [6:0] flags);
    rows[row_n].test  = 3'(test);
    rows[row_n].wr    = wr;
    rows[row_n].rd    = rd;
    rows[row_n].count = CW'(count);
    rows[row_n].flags = flags;
    row_n++;
  endtask

  // flags are empty, aempty, pempty, half, full, afull, pfull
  task automatic load_table();
    add_row(0, 1'b0, 1'b0, 0, 7'b1110000);
    // fill, prog full rises at 6
    add_row(1, 1'b1, 1'b0, 1, 7'b0110000);
    add_row(1, 1'b1, 1'b0, 2, 7'b0010000);
    add_row(1, 1'b1, 1'b0, 3, 7'b0010000);
    add_row(1, 1'b1, 1'b0, 4, 7'b0001000);
    add_row(1, 1'b1, 1'b0, 5, 7'b0001000);
    add_row(1, 1'b1, 1'b0, 6, 7'b0001001);
    add_row(1, 1'b1, 1'b0, 7, 7'b0001011);
    add_row(1, 1'b1, 1'b0, 8, 7'b0001111);
    // drain to 5, then write and read together
    add_row(2, 1'b0, 1'b1, 7, 7'b0001011);
    add_row(2, 1'b0, 1'b1, 6, 7'b0001001);
    add_row(2, 1'b0, 1'b1, 5, 7'b0001001);
    add_row(2, 1'b1, 1'b1, 5, 7'b0001001);
    add_row(2, 1'b1, 1'b1, 5, 7'b0001001);
    // prog full held at 4, drops at 3; prog empty rises at 2, held at 3
    add_row(3, 1'b0, 1'b1, 4, 7'b0001001);
    add_row(3, 1'b0, 1'b1, 3, 7'b0000000);
    add_row(3, 1'b0, 1'b1, 2, 7'b0010000);
    add_row(3, 1'b1, 1'b0, 3, 7'b0010000);
    add_row(3, 1'b1, 1'b0, 4, 7'b0001000);
    // drain to empty
    add_row(4, 1'b0, 1'b1, 3, 7'b0000000);
    add_row(4, 1'b0, 1'b1, 2, 7'b0010000);
    add_row(4, 1'b0, 1'b1, 1, 7'b0110000);
    add_row(4, 1'b0, 1'b1, 0, 7'b1110000);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int          i;
    int          err_mark;
    logic        end_test;
    logic [31:0] rnd;
    logic        wr_rand;
    logic        rd_rand;
    int          model_count;
    logic        model_pf;
    logic        model_pe;
    int          prev_count;
    logic [6:0]  new_flags;
    logic [6:0]  prev_flags;

    wr_i    = 1'b0;
    rd_i    = 1'b0;
    a_rst_i = 1'b1;
    err_mark = 0;
    load_table();

    repeat (4) @(posedge clk_i);
    a_rst_i <= 1'b0;

    // a row drives at one edge and is checked after the next
    for (i = 0; i <= NUM_ROWS; i++) begin
      @(posedge clk_i);
      if (i < NUM_ROWS) begin
        wr_i <= rows[i].wr;
        rd_i <= rows[i].rd;
      end else begin
        wr_i <= 1'b0;
        rd_i <= 1'b0;
      end
      @(negedge clk_i);
      if (i > 0) begin
        check_outputs(int'(rows[i-1].count), rows[i-1].flags);
        if (i == NUM_ROWS) begin
          end_test = 1'b1;
        end else begin
          end_test = (rows[i].test != rows[i-1].test);
        end
        if (end_test) begin
          report_test(int'(rows[i-1].test), err_mark);
        end
      end
    end

    // model starts where the table left the FIFO, empty
    model_count = 0;
    model_pf    = 1'b0;
    model_pe    = 1'b1;
    prev_count  = 0;
    prev_flags  = '0;
    new_flags   = '0;
    for (i = 0; i <= RAND_CYCLES; i++) begin
      @(posedge clk_i);
      if (i < RAND_CYCLES) begin
        rnd     = $random(seed);
        wr_rand = rnd[0];
        rd_rand = rnd[1];
        // no lone write when full, no read when empty
        if (model_count == DEPTH && wr_rand && !rd_rand) begin
          wr_rand = 1'b0;
        end
        if (model_count == 0) begin
          rd_rand = 1'b0;
        end
        wr_i <= wr_rand;
        rd_i <= rd_rand;
        if (wr_rand && !rd_rand) begin
          model_count++;
        end else if (rd_rand && !wr_rand) begin
          model_count--;
        end
        new_flags = rule_flags(model_count, model_pf, model_pe);
        model_pf  = new_flags[0];
        model_pe  = new_flags[4];
      end else begin
        wr_i <= 1'b0;
        rd_i <= 1'b0;
      end
      @(negedge clk_i);
      if (i > 0) begin
        check_outputs(prev_count, prev_flags);
      end
      prev_count = model_count;
      prev_flags = new_flags;
    end
    report_test(5, err_mark);

    $display("tests run %0d, tests failed %0d, checks %0d, check failures %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
design/fifo_status_pkg.sv
design/fifo_occupancy_counter.sv
design/fifo_fill_fsm.sv
design/fifo_threshold_flags.sv
design/fifo_status_top.sv
testbench/tb_fifo_status.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the FIFO status testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fifo_status -f build.f -o sim_fifo_status

# the log decides the result, so a stopped run is not fatal here
./obj_dir/sim_fifo_status > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
